/* source/lspc_consts.svh */
`ifndef LSPC_CONSTS_SVH
`define LSPC_CONSTS_SVH

// VRAM word address width, 2048 words
`define LSPC_VRAM_AW 11

// Clock cycles in one raster line
`define LSPC_LINE_CYCLES 8

// Raster lines in one frame
`define LSPC_LINES 264

// Video mode bit in the mode readback, 0 is NTSC
`define LSPC_VMODE 1'b0

// Width of the access slot counter
// CPU gets the slot when it is all ones
`define LSPC_SLOT_BITS 2

`endif

/* source/lspc_pkg.sv */
package lspc_pkg;

	// Host register map, addresses 4 to 7 are left unnamed
	typedef enum logic [2:0]
	{
		regVramAddr = 3'd0,
		regVramRw   = 3'd1,
		regVramMod  = 3'd2,
		regLspcMode = 3'd3
	} regAddrE;

	// Bus unit handshake states
	typedef enum logic [1:0]
	{
		busIdle,
		busWait,
		busAck
	} busStateE;

	// Commands from the bus unit to the VRAM access unit
	typedef enum logic [1:0]
	{
		cmdSetAddr,
		cmdSetMod,
		cmdWrite,
		cmdRead
	} vramCmdE;

	// VRAM access unit states
	typedef enum logic
	{
		vramIdle,
		vramSlotWait
	} vramStateE;

endpackage

/* source/cpuBus.sv */
`timescale 1ns/1ns

module cpuBus (
	input  logic                  clk24m,
	input  logic                  rst,
	input  logic                  req,
	output logic                  ack,
	input  logic [2:0]            addr,
	input  logic                  we,
	input  logic [15:0]           wdata,
	output logic [15:0]           rdata,
	output logic                  vramStart,
	output lspc_pkg::vramCmdE     vramCmd,
	input  logic                  vramDone,
	input  logic [15:0]           vramRdata,
	input  logic [15:0]           vramMod,
	output logic                  modeWrite,
	input  logic [15:0]           lspcMode
);

	lspc_pkg::busStateE state;
	lspc_pkg::vramCmdE  cmdNext;
	logic               useVram;
	logic               modeWr;
	logic               accessDone;
	logic [15:0]        readWord;

	// Register decode, host holds addr and we while req is high
	always_comb
	begin
		useVram = 1'b0;
		modeWr  = 1'b0;
		cmdNext = lspc_pkg::cmdRead;
		readWord = 16'h0000;
		case (lspc_pkg::regAddrE'(addr))
			lspc_pkg::regVramAddr:
			begin
				useVram  = 1'b1;
				cmdNext  = we ? lspc_pkg::cmdSetAddr : lspc_pkg::cmdRead;
				readWord = vramRdata;
			end
			lspc_pkg::regVramRw:
			begin
				useVram  = 1'b1;
				cmdNext  = we ? lspc_pkg::cmdWrite : lspc_pkg::cmdRead;
				readWord = vramRdata;
			end
			lspc_pkg::regVramMod:
			begin
				// Modulo reads are served locally
				useVram  = we;
				cmdNext  = lspc_pkg::cmdSetMod;
				readWord = vramMod;
			end
			lspc_pkg::regLspcMode:
			begin
				modeWr   = we;
				readWord = lspcMode;
			end
			default:
			begin
				// Timer and IRQ registers are not part of this block
				readWord = 16'h0000;
			end
		endcase
	end

	assign accessDone = useVram ? vramDone : 1'b1;

	always_ff @(posedge clk24m)
	begin
		if (rst)
		begin
			state     <= lspc_pkg::busIdle;
			ack       <= 1'b0;
			vramStart <= 1'b0;
			vramCmd   <= lspc_pkg::cmdSetAddr;
			modeWrite <= 1'b0;
		end
		else
		begin
			vramStart <= 1'b0;
			modeWrite <= 1'b0;
			case (state)
				lspc_pkg::busIdle:
				begin
					if (req)
					begin
						vramStart <= useVram;
						vramCmd   <= cmdNext;
						modeWrite <= modeWr;
						state     <= lspc_pkg::busWait;
					end
				end
				lspc_pkg::busWait:
				begin
					if (accessDone)
						state <= lspc_pkg::busAck;
				end
				default:
				begin
					// Four-phase return
					if (!ack)
						ack <= 1'b1;
					else if (!req)
					begin
						ack   <= 1'b0;
						state <= lspc_pkg::busIdle;
					end
				end
			endcase
		end
	end

	// Read word is held until the next read completes
	always_ff @(posedge clk24m)
	begin
		if (state == lspc_pkg::busWait && accessDone && !we)
			rdata <= readWord;
	end

endmodule

/* source/vramAccess.sv */
`timescale 1ns/1ns
`include "lspc_consts.svh"

module vramAccess (
	input  logic                  clk24m,
	input  logic                  rst,
	input  logic                  vramStart,
	input  lspc_pkg::vramCmdE     vramCmd,
	input  logic [15:0]           wdata,
	output logic                  vramDone,
	output logic [15:0]           vramRdata,
	output logic [15:0]           vramMod
);

	localparam int VramWords = 1 << `LSPC_VRAM_AW;

	logic [15:0]                vram [VramWords];
	logic [15:0]                vramAddr;
	logic [`LSPC_SLOT_BITS-1:0] slotCnt;
	lspc_pkg::vramStateE        state;
	lspc_pkg::vramCmdE          pendCmd;
	lspc_pkg::vramCmdE          accessCmd;
	logic                       slotFree;
	logic                       dataCmd;
	logic                       accessNow;

	// Video fetch owns the other slots
	assign slotFree = &slotCnt;

	assign dataCmd = (vramCmd == lspc_pkg::cmdWrite) || (vramCmd == lspc_pkg::cmdRead);

	assign accessCmd = (state == lspc_pkg::vramIdle) ? vramCmd : pendCmd;

	// Data access happens in the CPU slot, either at once or after waiting
	assign accessNow = slotFree &&
		((state == lspc_pkg::vramSlotWait) ||
		(state == lspc_pkg::vramIdle && vramStart && dataCmd));

	always_ff @(posedge clk24m)
	begin
		if (rst)
		begin
			slotCnt  <= '0;
			state    <= lspc_pkg::vramIdle;
			pendCmd  <= lspc_pkg::cmdRead;
			vramDone <= 1'b0;
			vramAddr <= 16'h0000;
			vramMod  <= 16'h0000;
		end
		else
		begin
			slotCnt  <= slotCnt + 1'b1;
			vramDone <= 1'b0;
			if (accessNow)
			begin
				vramDone <= 1'b1;
				state    <= lspc_pkg::vramIdle;
				// Auto-increment after a write only, wraps at 16 bits
				if (accessCmd == lspc_pkg::cmdWrite)
					vramAddr <= vramAddr + vramMod;
			end
			else if (state == lspc_pkg::vramIdle && vramStart)
			begin
				case (vramCmd)
					lspc_pkg::cmdSetAddr:
					begin
						vramAddr <= wdata;
						vramDone <= 1'b1;
					end
					lspc_pkg::cmdSetMod:
					begin
						vramMod  <= wdata;
						vramDone <= 1'b1;
					end
					default:
					begin
						pendCmd <= vramCmd;
						state   <= lspc_pkg::vramSlotWait;
					end
				endcase
			end
		end
	end

	// Array port, low address bits only
	always_ff @(posedge clk24m)
	begin
		if (accessNow)
		begin
			if (accessCmd == lspc_pkg::cmdWrite)
				vram[vramAddr[`LSPC_VRAM_AW-1:0]] <= wdata;
			else
				vramRdata <= vram[vramAddr[`LSPC_VRAM_AW-1:0]];
		end
	end

endmodule

/* source/animTimer.sv */
`timescale 1ns/1ns
`include "lspc_consts.svh"

module animTimer (
	input  logic        clk24m,
	input  logic        rst,
	input  logic        modeWrite,
	input  logic [15:0] wdata,
	output logic [15:0] lspcMode,
	output logic        vblank,
	output logic [8:0]  rasterLine
);

	localparam int CycW = $clog2(`LSPC_LINE_CYCLES);

	logic [CycW-1:0] cycleCnt;
	logic [8:0]      lineCnt;
	logic            lineEnd;
	logic            frameEnd;
	logic [7:0]      aaSpeed;
	logic            aaDisable;
	logic [7:0]      frameDiv;
	logic [2:0]      aaCount;

	assign lineEnd  = cycleCnt == CycW'(`LSPC_LINE_CYCLES - 1);
	assign frameEnd = lineEnd && (lineCnt == 9'(`LSPC_LINES - 1));

	// Raster position
	always_ff @(posedge clk24m)
	begin
		if (rst)
		begin
			cycleCnt <= '0;
			lineCnt  <= 9'd0;
			vblank   <= 1'b0;
		end
		else
		begin
			vblank <= frameEnd;
			if (lineEnd)
			begin
				cycleCnt <= '0;
				if (frameEnd)
					lineCnt <= 9'd0;
				else
					lineCnt <= lineCnt + 9'd1;
			end
			else
				cycleCnt <= cycleCnt + 1'b1;
		end
	end

	// Mode register and auto-animation, stepped once per vblank
	always_ff @(posedge clk24m)
	begin
		if (rst)
		begin
			aaSpeed   <= 8'h00;
			aaDisable <= 1'b0;
			frameDiv  <= 8'h00;
			aaCount   <= 3'd0;
		end
		else if (modeWrite)
		begin
			aaSpeed   <= wdata[15:8];
			aaDisable <= wdata[3];
			frameDiv  <= 8'h00;
		end
		else if (vblank)
		begin
			if (!aaDisable && frameDiv == aaSpeed)
			begin
				aaCount  <= aaCount + 3'd1;
				frameDiv <= 8'h00;
			end
			else
				frameDiv <= frameDiv + 8'h01;
		end
	end

	assign rasterLine = lineCnt;

	// Readback layout: line, three zeros, video mode, tile count
	assign lspcMode = {lineCnt, 3'b000, `LSPC_VMODE, aaCount};

endmodule

/* source/lspcCpuRegs.sv */
`timescale 1ns/1ns

module lspcCpuRegs (
	input  logic        clk24m,
	input  logic        rst,
	input  logic        req,
	output logic        ack,
	input  logic [2:0]  addr,
	input  logic        we,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	output logic        vblank,
	output logic [8:0]  rasterLine
);

	logic              vramStart;
	lspc_pkg::vramCmdE vramCmd;
	logic              vramDone;
	logic [15:0]       vramRdata;
	logic [15:0]       vramMod;
	logic              modeWrite;
	logic [15:0]       lspcMode;

	// Host side decode and read combining
	cpuBus bus (
		.clk24m    (clk24m),
		.rst       (rst),
		.req       (req),
		.ack       (ack),
		.addr      (addr),
		.we        (we),
		.wdata     (wdata),
		.rdata     (rdata),
		.vramStart (vramStart),
		.vramCmd   (vramCmd),
		.vramDone  (vramDone),
		.vramRdata (vramRdata),
		.vramMod   (vramMod),
		.modeWrite (modeWrite),
		.lspcMode  (lspcMode)
	);

	vramAccess vram (
		.clk24m    (clk24m),
		.rst       (rst),
		.vramStart (vramStart),
		.vramCmd   (vramCmd),
		.wdata     (wdata),
		.vramDone  (vramDone),
		.vramRdata (vramRdata),
		.vramMod   (vramMod)
	);

	// Raster counters and auto-animation
	animTimer anim (
		.clk24m     (clk24m),
		.rst        (rst),
		.modeWrite  (modeWrite),
		.wdata      (wdata),
		.lspcMode   (lspcMode),
		.vblank     (vblank),
		.rasterLine (rasterLine)
	);

endmodule

/* bench/lspcCpuRegs_sva.sv */
`timescale 1ns/1ns

module lspcCpuRegs_sva (
	input logic clk24m,
	input logic rst,
	input logic req,
	input logic ack,
	input logic vblank
);

	// Host handshake
	ackNeedsReq: assert property (@(posedge clk24m) disable iff (rst) $rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	ackHeld: assert property (@(posedge clk24m) disable iff (rst) (ack && req) |=> ack)
		else $error("ack fell while req was still high");

	ackResetLow: assert property (@(posedge clk24m) rst |=> !ack)
		else $error("ack high after a reset cycle");

	// Frame wrap pulse
	vblankPulse: assert property (@(posedge clk24m) disable iff (rst) vblank |=> !vblank)
		else $error("vblank high on two consecutive cycles");

endmodule

/* bench/lspcChecker.sv */
`timescale 1ns/1ns
`include "lspc_consts.svh"

module lspcChecker (
	input  logic        clk24m,
	input  logic        rst,
	input  logic        req,
	input  logic        ack,
	input  logic [2:0]  addr,
	input  logic        we,
	input  logic [15:0] wdata,
	input  logic [15:0] rdata,
	input  logic        vblank,
	input  logic [8:0]  rasterLine,
	output int          errorCount
);

	logic [15:0] shadowMem [1 << `LSPC_VRAM_AW];
	logic [15:0] shadowAddr;
	logic [15:0] shadowMod;
	logic [8:0]  line;
	int          cycInLine;
	logic        expVblank;
	logic        frameEnd;
	logic [7:0]  aaSpeed;
	logic        aaDisable;
	logic [7:0]  frameDiv;
	logic [2:0]  aaCount;
	logic [15:0] modeHist [3];
	logic        reqPrev;
	logic        ackPrev;
	logic [2:0]  curAddr;
	logic        curWe;
	logic [15:0] expWord;

	function automatic logic [15:0] modeWord(input logic [8:0] ln, input logic [2:0] cnt);
		return {ln, 3'b000, `LSPC_VMODE, cnt};
	endfunction

	// Expected read word for a register address
	function automatic logic [15:0] expectedRead(input logic [2:0] a);
		case (a)
			lspc_pkg::regVramAddr,
			lspc_pkg::regVramRw:
				return shadowMem[shadowAddr[`LSPC_VRAM_AW-1:0]];
			lspc_pkg::regVramMod:
				return shadowMod;
			lspc_pkg::regLspcMode:
				// Mode word is captured two cycles before ack shows up here
				return modeHist[2];
			default:
				return 16'h0000;
		endcase
	endfunction

	always @(posedge clk24m)
	begin
		if (rst)
		begin
			errorCount  = 0;
			shadowAddr  = 16'h0000;
			shadowMod   = 16'h0000;
			line        = 9'd0;
			cycInLine   = 0;
			expVblank   = 1'b0;
			aaSpeed     = 8'h00;
			aaDisable   = 1'b0;
			frameDiv    = 8'h00;
			aaCount     = 3'd0;
			modeHist[0] = 16'h0000;
			modeHist[1] = 16'h0000;
			modeHist[2] = 16'h0000;
			reqPrev     = 1'b0;
			ackPrev     = 1'b0;
			curAddr     = 3'd0;
			curWe       = 1'b0;
		end
		else
		begin
			modeHist[2] = modeHist[1];
			modeHist[1] = modeHist[0];
			modeHist[0] = modeWord(line, aaCount);
			if (rasterLine !== line)
			begin
				$display("FAILED rasterLine: got %h expected %h", rasterLine, line);
				errorCount++;
			end
			if (vblank !== expVblank)
			begin
				$display("FAILED vblank: got %h expected %h", vblank, expVblank);
				errorCount++;
			end
			if (ack && !ackPrev && !curWe)
			begin
				expWord = expectedRead(curAddr);
				if (rdata !== expWord)
				begin
					$display("FAILED rdata reg %0d: got %h expected %h", curAddr, rdata, expWord);
					errorCount++;
				end
			end

			// Raster position
			// vblank follows the wrap of the last line
			frameEnd  = (cycInLine == `LSPC_LINE_CYCLES - 1) && (line == 9'(`LSPC_LINES - 1));
			expVblank = frameEnd;
			if (cycInLine == `LSPC_LINE_CYCLES - 1)
			begin
				cycInLine = 0;
				line = frameEnd ? 9'd0 : line + 9'd1;
			end
			else
				cycInLine++;

			// Tile counter steps on vblank once the divider reaches the speed
			if (vblank)
			begin
				if (!aaDisable && frameDiv == aaSpeed)
				begin
					aaCount  = aaCount + 3'd1;
					frameDiv = 8'h00;
				end
				else
					frameDiv = frameDiv + 8'h01;
			end

			if (req && !reqPrev)
			begin
				curAddr = addr;
				curWe   = we;
				if (we)
				begin
					case (addr)
						lspc_pkg::regVramAddr:
							shadowAddr = wdata;
						lspc_pkg::regVramRw:
						begin
							shadowMem[shadowAddr[`LSPC_VRAM_AW-1:0]] = wdata;
							shadowAddr = shadowAddr + shadowMod;
						end
						lspc_pkg::regVramMod:
							shadowMod = wdata;
						lspc_pkg::regLspcMode:
						begin
							aaSpeed   = wdata[15:8];
							aaDisable = wdata[3];
							frameDiv  = 8'h00;
						end
					endcase
				end
			end
			reqPrev = req;
			ackPrev = ack;
		end
	end

endmodule

/* bench/lspcCpuRegs_tb.sv */
`timescale 1ns/1ns
`include "lspc_consts.svh"

module lspcCpuRegs_tb;

	localparam int AckTimeout  = 32;
	localparam int VblankLimit = `LSPC_LINE_CYCLES * `LSPC_LINES + 16;

	logic        clk24m;
	logic        rst;
	logic        req;
	logic        ack;
	logic [2:0]  addr;
	logic        we;
	logic [15:0] wdata;
	logic [15:0] rdata;
	logic        vblank;
	logic [8:0]  rasterLine;
	int          errorCount;
	int          timeoutCount;
	logic        timedOut;
	logic [31:0] seed;

	lspcCpuRegs DUT (
		.clk24m     (clk24m),
		.rst        (rst),
		.req        (req),
		.ack        (ack),
		.addr       (addr),
		.we         (we),
		.wdata      (wdata),
		.rdata      (rdata),
		.vblank     (vblank),
		.rasterLine (rasterLine)
	);

	// Shadow model and read compare
	lspcChecker readCheck (
		.clk24m     (clk24m),
		.rst        (rst),
		.req        (req),
		.ack        (ack),
		.addr       (addr),
		.we         (we),
		.wdata      (wdata),
		.rdata      (rdata),
		.vblank     (vblank),
		.rasterLine (rasterLine),
		.errorCount (errorCount)
	);

	bind lspcCpuRegs lspcCpuRegs_sva sva (
		.clk24m (clk24m),
		.rst    (rst),
		.req    (req),
		.ack    (ack),
		.vblank (vblank)
	);

	initial
	begin
		clk24m = 1'b0;
		forever
			#4 clk24m = ~clk24m;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic randWord(output logic [15:0] v);
		seed = lcgNext(seed);
		v = seed[31:16];
	endtask

	// One full four-phase host access
	// Skipped once a wait has timed out
	task automatic hostAccess(input logic [2:0] a, input logic w, input logic [15:0] d);
		int          n;
		logic [15:0] hold;
		if (!timedOut)
		begin
			@(negedge clk24m);
			addr  = a;
			we    = w;
			wdata = d;
			req   = 1'b1;
			n = 0;
			while (!ack && n < AckTimeout)
			begin
				@(negedge clk24m);
				n++;
			end
			if (!ack)
			begin
				req = 1'b0;
				$display("Timeout: no ack for access to register %0d", a);
				timedOut = 1'b1;
				timeoutCount++;
			end
			else
			begin
				// Host may keep req up for a few cycles after ack
				randWord(hold);
				repeat (hold[1:0]) @(negedge clk24m);
				req = 1'b0;
				n = 0;
				while (ack && n < AckTimeout)
				begin
					@(negedge clk24m);
					n++;
				end
				if (ack)
				begin
					$display("Timeout: ack stayed high after req fell");
					timedOut = 1'b1;
					timeoutCount++;
				end
			end
		end
	endtask

	task automatic waitVblank();
		int n;
		if (!timedOut)
		begin
			@(negedge clk24m);
			n = 0;
			while (!vblank && n < VblankLimit)
			begin
				@(negedge clk24m);
				n++;
			end
			if (!vblank)
			begin
				$display("Timeout: no vblank within one frame");
				timedOut = 1'b1;
				timeoutCount++;
			end
		end
	endtask

	initial
	begin
		logic [15:0] base;
		logic [15:0] step;
		logic [15:0] a;
		logic [15:0] val;
		int          speed;
		rst          = 1'b1;
		req          = 1'b0;
		addr         = 3'd0;
		we           = 1'b0;
		wdata        = 16'h0000;
		seed         = 32'h75d0;
		timedOut     = 1'b0;
		timeoutCount = 0;
		repeat (16) @(negedge clk24m);
		rst = 1'b0;
		repeat (2) @(negedge clk24m);

		// Burst of writes stepping by a small modulo and a read back
		randWord(base);
		randWord(step);
		step = {12'h000, step[3:0]} + 16'd1;
		hostAccess(lspc_pkg::regVramAddr, 1'b1, base);
		hostAccess(lspc_pkg::regVramMod, 1'b1, step);
		for (int i = 0; i < 8; i++)
		begin
			randWord(val);
			hostAccess(lspc_pkg::regVramRw, 1'b1, val);
		end
		a = base;
		for (int i = 0; i < 8; i++)
		begin
			hostAccess(lspc_pkg::regVramAddr, 1'b1, a);
			hostAccess(lspc_pkg::regVramRw, 1'b0, 16'h0000);
			a = a + step;
		end

		// Reads leave the address alone
		hostAccess(lspc_pkg::regVramAddr, 1'b1, base + step);
		hostAccess(lspc_pkg::regVramRw, 1'b0, 16'h0000);
		hostAccess(lspc_pkg::regVramRw, 1'b0, 16'h0000);
		hostAccess(lspc_pkg::regVramAddr, 1'b0, 16'h0000);
		hostAccess(lspc_pkg::regVramAddr, 1'b0, 16'h0000);

		// Large modulo makes the address wrap at 16 bits
		randWord(step);
		step = step | 16'hf000;
		hostAccess(lspc_pkg::regVramMod, 1'b1, step);
		hostAccess(lspc_pkg::regVramMod, 1'b0, 16'h0000);
		randWord(base);
		base = base | 16'hff00;
		hostAccess(lspc_pkg::regVramAddr, 1'b1, base);
		for (int i = 0; i < 4; i++)
		begin
			randWord(val);
			hostAccess(lspc_pkg::regVramRw, 1'b1, val);
		end
		a = base;
		for (int i = 0; i < 4; i++)
		begin
			hostAccess(lspc_pkg::regVramAddr, 1'b1, a);
			hostAccess(lspc_pkg::regVramRw, 1'b0, 16'h0000);
			a = a + step;
		end

		// Timer and IRQ addresses are ignored
		for (int i = 4; i < 8; i++)
		begin
			randWord(val);
			hostAccess(3'(i), 1'b1, val);
			hostAccess(3'(i), 1'b0, 16'h0000);
		end
		hostAccess(lspc_pkg::regVramRw, 1'b0, 16'h0000);
		hostAccess(lspc_pkg::regVramMod, 1'b0, 16'h0000);
		hostAccess(lspc_pkg::regLspcMode, 1'b0, 16'h0000);

		// Auto-animation at a random speed and then with the disable bit
		randWord(val);
		speed = int'(val % 16'd3);
		waitVblank();
		hostAccess(lspc_pkg::regLspcMode, 1'b1, {8'(speed), 8'h00});
		for (int i = 0; i < 2 * speed + 3; i++)
		begin
			waitVblank();
			hostAccess(lspc_pkg::regLspcMode, 1'b0, 16'h0000);
		end
		waitVblank();
		hostAccess(lspc_pkg::regLspcMode, 1'b1, {8'(speed), 8'h08});
		for (int i = 0; i < 3; i++)
		begin
			waitVblank();
			hostAccess(lspc_pkg::regLspcMode, 1'b0, 16'h0000);
		end

		repeat (4) @(negedge clk24m);
		$display("Errors: %0d compare, %0d timeout", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+source
source/lspc_pkg.sv
source/cpuBus.sv
source/vramAccess.sv
source/animTimer.sv
source/lspcCpuRegs.sv
bench/lspcCpuRegs_sva.sv
bench/lspcChecker.sv
bench/lspcCpuRegs_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the LSPC register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module lspcCpuRegs_tb -f verilog.f -o lspcSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

simOut=$(./obj_dir/lspcSim 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx "Finished with no errors"; then
	exit 0
fi
echo "Simulation did not pass"
exit 1
